//--- bench/tb_swu.sv
`timescale 1ns/1ps

module tb_swu;

   import swu_geom_pkg::*;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 8;

   localparam int IFM_W      = IFM_W_DEF;
   localparam int IFM_H      = IFM_H_DEF;
   localparam int CH_GROUPS  = CH_GROUPS_DEF;
   localparam int KERNEL     = KERNEL_DEF;
   localparam int STRIDE     = STRIDE_DEF;
   localparam int LANES      = LANES_DEF;
   localparam int OFM_W      = (IFM_W - KERNEL)/STRIDE + 1;
   localparam int OFM_H      = (IFM_H - KERNEL)/STRIDE + 1;
   localparam int COL_GROUPS = OFM_W/LANES;
   localparam int FRAME_LEN  = IFM_W*IFM_H*CH_GROUPS;
   localparam int OUT_LEN    = OFM_H*COL_GROUPS*KERNEL*KERNEL*CH_GROUPS;
   localparam int OUT_W      = LANES*SIMD*ELEM_W;
   localparam int N_FRAMES   = 6;

   // four times the nominal length of all frames, at up to four cycles per word
   localparam int WATCHDOG_CYCLES = 4*(N_FRAMES*(FRAME_LEN + OUT_LEN)*4);

   logic              aclk;
   logic              aresetn;
   word_t             s_tdata_i;
   logic              s_tvalid_i;
   logic              s_tready_o;
   word_t [LANES-1:0] m_tdata_o;
   logic              m_tvalid_o;
   logic              m_tready_i;

   integer seed;
   string  test_name;
   logic   ready_random;
   int     in_total;
   int     out_total;

   // every accepted input word, all frames in a row
   word_t frame_words [N_FRAMES*FRAME_LEN];

   swu_top uut (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .s_tdata_i  (s_tdata_i),
      .s_tvalid_i (s_tvalid_i),
      .s_tready_o (s_tready_o),
      .m_tdata_o  (m_tdata_o),
      .m_tvalid_o (m_tvalid_o),
      .m_tready_i (m_tready_i)
   );

   always #(CLK_PERIOD/2) aclk = ~aclk;

   // expected lanes for output word idx of a frame, from the im2col order
   function automatic logic [OUT_W-1:0] ref_window(input int frame, input int idx);
      int ch;
      int kw;
      int kh;
      int g;
      int oy;
      int addr;
      logic [OUT_W-1:0] r;
      ch = idx % CH_GROUPS;
      kw = (idx/CH_GROUPS) % KERNEL;
      kh = (idx/(CH_GROUPS*KERNEL)) % KERNEL;
      g  = (idx/(CH_GROUPS*KERNEL*KERNEL)) % COL_GROUPS;
      oy = idx/(CH_GROUPS*KERNEL*KERNEL*COL_GROUPS);
      for (int l = 0; l < LANES; l++) begin
         addr = ((oy*STRIDE + kh)*IFM_W + (g*LANES + l)*STRIDE + kw)*CH_GROUPS + ch;
         r[l*SIMD*ELEM_W +: SIMD*ELEM_W] = frame_words[frame*FRAME_LEN + addr];
      end
      return r;
   endfunction

   task automatic check(input string what, input logic [OUT_W-1:0] expected,
                        input logic [OUT_W-1:0] actual);
      if (expected !== actual) begin
         $display("mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
         $display("test failed");
         $fatal(1, "stopping at the first error");
      end
   endtask

   // feeds one frame, keeping data stable while valid waits for ready
   task automatic send_frame(input int frame, input bit incr, input bit gaps);
      int   i;
      int   n;
      logic accepted;
      i = 0;
      while (i < FRAME_LEN) begin
         if (!s_tvalid_i && !(gaps && (($random(seed) & 3) == 0))) begin
            n = frame*FRAME_LEN + i;
            s_tvalid_i = 1'b1;
            if (incr) begin
               s_tdata_i = {8'(4*n + 3), 8'(4*n + 2), 8'(4*n + 1), 8'(4*n)};
            end else begin
               s_tdata_i = $random(seed);
            end
         end
         @(posedge aclk);
         accepted = s_tvalid_i && s_tready_o;
         #1;
         if (accepted) begin
            i++;
            s_tvalid_i = 1'b0;
         end
      end
   endtask

   task automatic wait_outputs(input int frames);
      while (out_total < frames*OUT_LEN) begin
         @(posedge aclk);
      end
      #1;
   endtask

   always @(posedge aclk) begin
      #1;
      if (ready_random) begin
         m_tready_i = (($random(seed) & 1) == 1);
      end else begin
         m_tready_i = 1'b1;
      end
   end

   // port monitor and comparator
   always @(posedge aclk) begin
      if (!aresetn) begin
         check("valid during reset", '0, OUT_W'(m_tvalid_o));
      end else begin
         if (m_tvalid_o) begin
            check("valid before frame filled", OUT_W'(1),
                  OUT_W'(in_total >= (out_total/OUT_LEN + 1)*FRAME_LEN));
         end
         if (s_tvalid_i && s_tready_o) begin
            if (in_total > 0 && in_total % FRAME_LEN == 0) begin
               // a new frame only starts once the previous one is fully out
               check("outputs before next frame", OUT_W'((in_total/FRAME_LEN)*OUT_LEN),
                     OUT_W'(out_total));
            end
            frame_words[in_total] = s_tdata_i;
            in_total++;
         end
         if (m_tvalid_o && m_tready_i) begin
            check("output word", ref_window(out_total/OUT_LEN, out_total % OUT_LEN),
                  m_tdata_o);
            out_total++;
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge aclk);
      $display("watchdog expired before all output words were transferred");
      $display("test failed");
      $fatal(1, "run timed out");
   end

   initial begin
      seed         = 76;
      aclk         = 1'b0;
      aresetn      = 1'b0;
      s_tdata_i    = '0;
      s_tvalid_i   = 1'b0;
      m_tready_i   = 1'b0;
      ready_random = 1'b0;
      in_total     = 0;
      out_total    = 0;
      test_name    = "reset";
      repeat (RESET_CYCLES) @(posedge aclk);
      #1;
      aresetn = 1'b1;
      @(posedge aclk);
      check("ready after reset", OUT_W'(1), OUT_W'(s_tready_o));
      #1;

      test_name = "incr_ready_high";
      send_frame(0, 1'b1, 1'b0);
      wait_outputs(1);

      test_name    = "random_ready";
      ready_random = 1'b1;
      send_frame(1, 1'b0, 1'b0);
      wait_outputs(2);

      test_name    = "input_gaps";
      ready_random = 1'b0;
      send_frame(2, 1'b0, 1'b1);
      wait_outputs(3);

      // later frames stall at the input while the previous one scans
      test_name    = "back_to_back";
      ready_random = 1'b1;
      send_frame(3, 1'b0, 1'b1);
      send_frame(4, 1'b0, 1'b0);
      send_frame(5, 1'b0, 1'b1);
      wait_outputs(N_FRAMES);

      repeat (20) @(posedge aclk);
      check("total outputs", OUT_W'(N_FRAMES*OUT_LEN), OUT_W'(out_total));
      $display("test passed");
      $finish;
   end

endmodule

//--- hw/swu_ctrl_pkg.sv
package swu_ctrl_pkg;

   // fill the frame, scan all windows, then wait for the output to empty
   typedef enum logic [1:0] {
      ST_FILL,
      ST_SCAN,
      ST_DRAIN
   } sched_state_e;

endpackage

//--- hw/swu_geom_pkg.sv
package swu_geom_pkg;

   // element and word geometry
   localparam int ELEM_W = 8;
   localparam int SIMD   = 4;

   // one channel group of SIMD elements
   typedef logic [SIMD*ELEM_W-1:0] word_t;

   // default frame and kernel geometry
   localparam int IFM_W_DEF     = 5;
   localparam int IFM_H_DEF     = 5;
   localparam int CH_GROUPS_DEF = 2;
   localparam int KERNEL_DEF    = 3;
   localparam int STRIDE_DEF    = 1;

   // output columns produced side by side
   localparam int LANES_DEF = 3;

endpackage

//--- hw/swu_lane.sv
`timescale 1ns/1ps

module swu_lane #(
   parameter int LANE_IDX  = 0,
   parameter int IFM_W     = 5,
   parameter int IFM_H     = 5,
   parameter int CH_GROUPS = 2,
   parameter int STRIDE    = 1,
   localparam int FRAME_LEN = IFM_W*IFM_H*CH_GROUPS,
   localparam int ADDR_W    = $clog2(FRAME_LEN)
) (
   input  logic                 aclk,
   input  logic                 wr_en_i,
   input  logic [ADDR_W-1:0]    wr_addr_i,
   input  swu_geom_pkg::word_t  wr_data_i,
   input  logic                 rd_en_i,
   input  logic [ADDR_W-1:0]    rd_base_i,
   output swu_geom_pkg::word_t  rd_data_o
);

   import swu_geom_pkg::*;

   // this lane sits LANE_IDX output columns to the right of lane 0
   localparam int COL_OFFSET = LANE_IDX*STRIDE*CH_GROUPS;

   word_t mem [FRAME_LEN];

   logic [ADDR_W-1:0] rd_addr;

   assign rd_addr = rd_base_i + ADDR_W'(COL_OFFSET);

   // every lane holds the same frame
   always_ff @(posedge aclk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   always_ff @(posedge aclk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr];
      end
   end

endmodule

//--- hw/swu_out_stage.sv
`timescale 1ns/1ps

module swu_out_stage #(
   parameter int LANES = 3
) (
   input  logic                             aclk,
   input  logic                             aresetn,
   input  logic                             rd_en_i,
   input  swu_geom_pkg::word_t [LANES-1:0]  rd_data_i,
   output logic                             rd_ready_o,
   output logic                             idle_o,
   output swu_geom_pkg::word_t [LANES-1:0]  m_tdata_o,
   output logic                             m_tvalid_o,
   input  logic                             m_tready_i
);

   import swu_geom_pkg::*;

   localparam int DEPTH = 2;

   word_t [LANES-1:0] entry_q [DEPTH];

   // reads issued but not yet landed
   logic       infl_q;
   // buffered words plus reads in flight
   logic [1:0] occ_cnt;
   logic [1:0] buf_cnt;
   logic       wr_ptr;
   logic       rd_ptr;
   logic       pop;

   assign buf_cnt    = occ_cnt - {1'b0, infl_q};
   assign m_tvalid_o = (buf_cnt != 2'd0);
   assign m_tdata_o  = entry_q[rd_ptr];
   assign pop        = m_tvalid_o && m_tready_i;

   assign rd_ready_o = (occ_cnt < 2'(DEPTH));
   assign idle_o     = (occ_cnt == 2'd0);

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         infl_q  <= 1'b0;
         occ_cnt <= 2'd0;
         wr_ptr  <= 1'b0;
         rd_ptr  <= 1'b0;
      end else begin
         infl_q <= rd_en_i;
         case ({rd_en_i, pop})
            2'b10:   occ_cnt <= occ_cnt + 2'd1;
            2'b01:   occ_cnt <= occ_cnt - 2'd1;
            default: occ_cnt <= occ_cnt;
         endcase
         if (infl_q) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
      end
   end

   // lane data lands one cycle after its read
   always_ff @(posedge aclk) begin
      if (infl_q) begin
         entry_q[wr_ptr] <= rd_data_i;
      end
   end

endmodule

//--- hw/swu_scheduler.sv
`timescale 1ns/1ps

module swu_scheduler #(
   parameter int IFM_W     = 5,
   parameter int IFM_H     = 5,
   parameter int CH_GROUPS = 2,
   parameter int KERNEL    = 3,
   parameter int STRIDE    = 1,
   parameter int LANES     = 3,
   localparam int FRAME_LEN = IFM_W*IFM_H*CH_GROUPS,
   localparam int ADDR_W    = $clog2(FRAME_LEN)
) (
   input  logic              aclk,
   input  logic              aresetn,
   input  logic              s_tvalid_i,
   output logic              s_tready_o,
   input  logic              rd_ready_i,
   input  logic              out_idle_i,
   output logic              wr_en_o,
   output logic [ADDR_W-1:0] wr_addr_o,
   output logic              rd_en_o,
   output logic [ADDR_W-1:0] rd_base_o
);

   import swu_ctrl_pkg::*;

   localparam int OFM_W      = (IFM_W - KERNEL)/STRIDE + 1;
   localparam int OFM_H      = (IFM_H - KERNEL)/STRIDE + 1;
   localparam int COL_GROUPS = OFM_W/LANES;

   localparam int CH_W = $clog2(CH_GROUPS + 1);
   localparam int K_W  = $clog2(KERNEL + 1);
   localparam int CG_W = $clog2(COL_GROUPS + 1);
   localparam int OY_W = $clog2(OFM_H + 1);

   sched_state_e state_q;

   logic [ADDR_W-1:0] fill_cnt;
   logic              fill_last;

   logic [CH_W-1:0] ch_cnt;
   logic [K_W-1:0]  kw_cnt;
   logic [K_W-1:0]  kh_cnt;
   logic [CG_W-1:0] cg_cnt;
   logic [OY_W-1:0] oy_cnt;

   logic ch_last;
   logic kw_last;
   logic kh_last;
   logic cg_last;
   logic oy_last;
   logic scan_last;

   assign s_tready_o = (state_q == ST_FILL);
   assign wr_en_o    = s_tvalid_i && s_tready_o;
   assign wr_addr_o  = fill_cnt;
   assign fill_last  = (fill_cnt == ADDR_W'(FRAME_LEN - 1));

   assign rd_en_o = (state_q == ST_SCAN) && rd_ready_i;

   assign ch_last   = (ch_cnt == CH_W'(CH_GROUPS - 1));
   assign kw_last   = (kw_cnt == K_W'(KERNEL - 1));
   assign kh_last   = (kh_cnt == K_W'(KERNEL - 1));
   assign cg_last   = (cg_cnt == CG_W'(COL_GROUPS - 1));
   assign oy_last   = (oy_cnt == OY_W'(OFM_H - 1));
   assign scan_last = ch_last && kw_last && kh_last && cg_last && oy_last;

   // frame word of lane 0 for the current window element
   assign rd_base_o = ADDR_W'(((oy_cnt*STRIDE + kh_cnt)*IFM_W + cg_cnt*LANES*STRIDE + kw_cnt)
                              *CH_GROUPS + ch_cnt);

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state_q  <= ST_FILL;
         fill_cnt <= '0;
      end else begin
         case (state_q)
            ST_FILL: begin
               if (wr_en_o) begin
                  if (fill_last) begin
                     fill_cnt <= '0;
                     state_q  <= ST_SCAN;
                  end else begin
                     fill_cnt <= fill_cnt + 1'b1;
                  end
               end
            end
            ST_SCAN: begin
               if (rd_en_o && scan_last) begin
                  state_q <= ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               // reads already issued must leave before the next frame overwrites
               if (out_idle_i) begin
                  state_q <= ST_FILL;
               end
            end
            default: state_q <= ST_FILL;
         endcase
      end
   end

   // channel innermost, then kernel column, kernel row, column group, output row
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         ch_cnt <= '0;
         kw_cnt <= '0;
         kh_cnt <= '0;
         cg_cnt <= '0;
         oy_cnt <= '0;
      end else if (rd_en_o) begin
         ch_cnt <= ch_last ? '0 : ch_cnt + 1'b1;
         if (ch_last) begin
            kw_cnt <= kw_last ? '0 : kw_cnt + 1'b1;
            if (kw_last) begin
               kh_cnt <= kh_last ? '0 : kh_cnt + 1'b1;
               if (kh_last) begin
                  cg_cnt <= cg_last ? '0 : cg_cnt + 1'b1;
                  if (cg_last) begin
                     oy_cnt <= oy_last ? '0 : oy_cnt + 1'b1;
                  end
               end
            end
         end
      end
   end

endmodule

//--- hw/swu_top.sv
`timescale 1ns/1ps

module swu_top #(
   parameter int IFM_W     = swu_geom_pkg::IFM_W_DEF,
   parameter int IFM_H     = swu_geom_pkg::IFM_H_DEF,
   parameter int CH_GROUPS = swu_geom_pkg::CH_GROUPS_DEF,
   parameter int KERNEL    = swu_geom_pkg::KERNEL_DEF,
   parameter int STRIDE    = swu_geom_pkg::STRIDE_DEF,
   parameter int LANES     = swu_geom_pkg::LANES_DEF
) (
   input  logic                             aclk,
   input  logic                             aresetn,
   input  swu_geom_pkg::word_t              s_tdata_i,
   input  logic                             s_tvalid_i,
   output logic                             s_tready_o,
   output swu_geom_pkg::word_t [LANES-1:0]  m_tdata_o,
   output logic                             m_tvalid_o,
   input  logic                             m_tready_i
);

   import swu_geom_pkg::*;

   localparam int FRAME_LEN = IFM_W*IFM_H*CH_GROUPS;
   localparam int ADDR_W    = $clog2(FRAME_LEN);

   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic              rd_en;
   logic [ADDR_W-1:0] rd_base;
   logic              rd_ready;
   logic              out_idle;
   word_t [LANES-1:0] lane_data;

   swu_scheduler #(
      .IFM_W     (IFM_W),
      .IFM_H     (IFM_H),
      .CH_GROUPS (CH_GROUPS),
      .KERNEL    (KERNEL),
      .STRIDE    (STRIDE),
      .LANES     (LANES)
   ) u_sched (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .s_tvalid_i (s_tvalid_i),
      .s_tready_o (s_tready_o),
      .rd_ready_i (rd_ready),
      .out_idle_i (out_idle),
      .wr_en_o    (wr_en),
      .wr_addr_o  (wr_addr),
      .rd_en_o    (rd_en),
      .rd_base_o  (rd_base)
   );

   for (genvar l = 0; l < LANES; l++) begin : g_lane
      swu_lane #(
         .LANE_IDX  (l),
         .IFM_W     (IFM_W),
         .IFM_H     (IFM_H),
         .CH_GROUPS (CH_GROUPS),
         .STRIDE    (STRIDE)
      ) u_lane (
         .aclk      (aclk),
         .wr_en_i   (wr_en),
         .wr_addr_i (wr_addr),
         .wr_data_i (s_tdata_i),
         .rd_en_i   (rd_en),
         .rd_base_i (rd_base),
         .rd_data_o (lane_data[l])
      );
   end

   swu_out_stage #(
      .LANES (LANES)
   ) u_out (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .rd_en_i    (rd_en),
      .rd_data_i  (lane_data),
      .rd_ready_o (rd_ready),
      .idle_o     (out_idle),
      .m_tdata_o  (m_tdata_o),
      .m_tvalid_o (m_tvalid_o),
      .m_tready_i (m_tready_i)
   );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; pass is read from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_swu -f src.f -o tb_swu_sim \
   && ./obj_dir/tb_swu_sim > sim.log 2>&1 \
   || echo "build or simulation reported an error"
cat sim.log 2>/dev/null
grep -q "^test passed$" sim.log \
   && { echo "simulation PASS"; exit 0; } \
   || { echo "simulation FAIL"; exit 1; }

//--- src.f
hw/swu_geom_pkg.sv
hw/swu_ctrl_pkg.sv
hw/swu_scheduler.sv
hw/swu_lane.sv
hw/swu_out_stage.sv
hw/swu_top.sv
bench/tb_swu.sv
